// File: include/axi_master_defines.svh
// Widths, burst depth and response codes shared by the VLSU AXI4 burst master
// and its testbench

`ifndef AXI_MASTER_DEFINES_SVH
`define AXI_MASTER_DEFINES_SVH

// Full bus word, every beat uses all lanes
`define AXI_DATA_W 32

// Byte address width
`define AXI_ADDR_W 32

// Transaction ID width, IDs wrap after 16 requests
`define AXI_ID_W 4

// Deepest burst the request buffers can hold
`define BURST_MAX 8

// Response codes on R and B
`define RESP_OKAY   2'b00
`define RESP_SLVERR 2'b10

`endif

// File: hdl/axi_chan_pkg.sv
// Types for the AXI4 bus side of the burst master
// Covers IDs, addresses, lengths, beats, strobes and responses

`default_nettype none

`include "axi_master_defines.svh"

package axi_chan_pkg;

    // Transaction ID carried on AR, AW, R and B
    typedef logic [`AXI_ID_W-1:0] axi_id_t;

    // Byte address of the first beat
    typedef logic [`AXI_ADDR_W-1:0] axi_addr_t;

    // Burst length as beats minus one
    typedef logic [7:0] axi_len_t;

    // One full data word
    typedef logic [`AXI_DATA_W-1:0] axi_beat_t;

    // One strobe bit per byte lane
    typedef logic [`AXI_DATA_W/8-1:0] axi_strb_t;

    // OKAY, EXOKAY, SLVERR or DECERR
    typedef logic [1:0] axi_resp_t;

endpackage

`default_nettype wire

// File: hdl/vlsu_req_pkg.sv
// Types for the VLSU request side of the burst master

`default_nettype none

`include "axi_master_defines.svh"

package vlsu_req_pkg;

    // Kind of the request in flight
    typedef enum logic [1:0] {
        NONE  = 2'd0,
        LOAD  = 2'd1,
        STORE = 2'd2
    } req_kind_t;

    // Whole burst of words, beat 0 in the low bits
    typedef logic [`BURST_MAX*`AXI_DATA_W-1:0] burst_data_t;

    // Strobe groups matching burst_data_t
    typedef logic [`BURST_MAX*`AXI_DATA_W/8-1:0] burst_strb_t;

endpackage

`default_nettype wire

// File: hdl/axi_req_tracker.sv
// Request tracker for the VLSU AXI4 master
// Captures one load or store, assigns its ID and drives AR or AW, reissuing on retry

`timescale 1ns/1ps
`default_nettype none

module axi_req_tracker (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       ld_req,
    input  wire                       st_req,
    input  wire axi_chan_pkg::axi_addr_t   base_addr,
    input  wire axi_chan_pkg::axi_len_t    burst_len,
    input  wire vlsu_req_pkg::burst_data_t wdata_buf,
    input  wire vlsu_req_pkg::burst_strb_t wstrb_buf,
    input  wire                       arready,
    input  wire                       awready,
    input  wire                       retry,
    input  wire                       done,
    output logic                      arvalid,
    output logic                      awvalid,
    output axi_chan_pkg::axi_id_t     arid,
    output axi_chan_pkg::axi_id_t     awid,
    output axi_chan_pkg::axi_addr_t   araddr,
    output axi_chan_pkg::axi_addr_t   awaddr,
    output axi_chan_pkg::axi_len_t    arlen,
    output axi_chan_pkg::axi_len_t    awlen,
    output vlsu_req_pkg::req_kind_t   kind,
    output axi_chan_pkg::axi_id_t     cur_id,
    output axi_chan_pkg::axi_len_t    cur_len,
    output vlsu_req_pkg::burst_data_t cur_data,
    output vlsu_req_pkg::burst_strb_t cur_strb,
    output logic                      aw_sent,
    output logic                      addr_sent,
    output logic                      busy
);

    import axi_chan_pkg::*;
    import vlsu_req_pkg::*;

    axi_addr_t cur_addr;
    axi_id_t   next_id;
    logic      active;
    logic      accept;

    // Busy drops in the same cycle as the completion pulse
    assign busy   = active && !done;
    assign accept = (ld_req || st_req) && !busy;

    // ==========================================================================
    // Control state
    // ==========================================================================

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            active  <= 1'b0;
            kind    <= NONE;
            next_id <= '0;
            arvalid <= 1'b0;
            awvalid <= 1'b0;
        end else begin
            // Address accepted by the slave
            if (arvalid && arready)
                arvalid <= 1'b0;
            if (awvalid && awready)
                awvalid <= 1'b0;

            // Failed burst, raise the same channel again from the latched copy
            if (retry) begin
                arvalid <= (kind == LOAD);
                awvalid <= (kind == STORE);
            end

            if (done) begin
                active <= 1'b0;
                kind   <= NONE;
            end

            // New request, load wins if both pulse together
            if (accept) begin
                active  <= 1'b1;
                kind    <= ld_req ? LOAD : STORE;
                next_id <= next_id + 1'b1;
                arvalid <= ld_req;
                awvalid <= !ld_req;
            end
        end
    end

    // Latched copy of the request, reused unchanged on every retry
    always_ff @(posedge clk) begin
        if (accept) begin
            cur_id   <= next_id;
            cur_len  <= burst_len;
            cur_addr <= base_addr;
            cur_data <= wdata_buf;
            cur_strb <= wstrb_buf;
        end
    end

    // Both address channels carry the same latched payload
    assign arid   = cur_id;
    assign awid   = cur_id;
    assign araddr = cur_addr;
    assign awaddr = cur_addr;
    assign arlen  = cur_len;
    assign awlen  = cur_len;

    // Handshake pulses towards the beat counter and the response checker
    assign aw_sent   = awvalid && awready;
    assign addr_sent = (arvalid && arready) || aw_sent;

    // A stalled address keeps valid and payload until accepted
    a_ar_hold: assert property (@(posedge clk) disable iff (!reset)
        arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arid));
    a_aw_hold: assert property (@(posedge clk) disable iff (!reset)
        awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awid));

endmodule

`default_nettype wire

// File: hdl/axi_write_beats.sv
// Write beat sequencer for the VLSU AXI4 master
// Walks the store buffer onto the W channel once AW has been accepted

`timescale 1ns/1ps
`default_nettype none

`include "axi_master_defines.svh"

module axi_write_beats (
    input  wire                        clk,
    input  wire                        reset,
    input  wire vlsu_req_pkg::req_kind_t   kind,
    input  wire axi_chan_pkg::axi_len_t    cur_len,
    input  wire vlsu_req_pkg::burst_data_t cur_data,
    input  wire vlsu_req_pkg::burst_strb_t cur_strb,
    input  wire                        aw_sent,
    input  wire                        wready,
    output logic                       wvalid,
    output axi_chan_pkg::axi_beat_t    wdata,
    output axi_chan_pkg::axi_strb_t    wstrb,
    output logic                       wlast,
    output logic                       wlast_sent
);

    import axi_chan_pkg::*;
    import vlsu_req_pkg::*;

    // Beat currently on the bus
    axi_len_t idx;
    logic     w_hs;

    assign w_hs = wvalid && wready;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            wvalid <= 1'b0;
            idx    <= '0;
        end else if (aw_sent && kind == STORE) begin
            // Start from beat 0 on every issue, retries included
            wvalid <= 1'b1;
            idx    <= '0;
        end else if (w_hs) begin
            if (wlast)
                wvalid <= 1'b0;
            else
                idx <= idx + 1'b1;
        end
    end

    // Word and strobe group selected by the beat index
    assign wdata = cur_data[idx*`AXI_DATA_W +: `AXI_DATA_W];
    assign wstrb = cur_strb[idx*(`AXI_DATA_W/8) +: `AXI_DATA_W/8];

    assign wlast      = wvalid && (idx == cur_len);
    assign wlast_sent = w_hs && wlast;

    // Stalled beat keeps its word, strobes and last flag
    a_w_hold: assert property (@(posedge clk) disable iff (!reset)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb) && $stable(wlast));

    // Beat index never walks past the last beat of a store in flight
    a_idx_range: assert property (@(posedge clk) disable iff (!reset)
        wvalid |-> (idx <= cur_len) && (kind == STORE));

endmodule

`default_nettype wire

// File: hdl/axi_resp_check.sv
// Response checker for the VLSU AXI4 master
// Collects R beats, checks R and B for OKAY and ID, then signals retry or completion

`timescale 1ns/1ps
`default_nettype none

`include "axi_master_defines.svh"

module axi_resp_check (
    input  wire                         clk,
    input  wire                         reset,
    input  wire vlsu_req_pkg::req_kind_t    kind,
    input  wire axi_chan_pkg::axi_id_t      cur_id,
    input  wire                         addr_sent,
    input  wire                         wlast_sent,
    input  wire                         rvalid,
    input  wire axi_chan_pkg::axi_id_t      rid,
    input  wire axi_chan_pkg::axi_beat_t    rdata,
    input  wire axi_chan_pkg::axi_resp_t    rresp,
    input  wire                         rlast,
    input  wire                         bvalid,
    input  wire axi_chan_pkg::axi_id_t      bid,
    input  wire axi_chan_pkg::axi_resp_t    bresp,
    output logic                        rready,
    output logic                        bready,
    output vlsu_req_pkg::burst_data_t   rdata_buf,
    output logic                        load_done,
    output logic                        store_done,
    output logic                        retry,
    output logic                        done
);

    import axi_chan_pkg::*;
    import vlsu_req_pkg::*;

    axi_len_t rd_idx;
    // Sticky over the burst, cleared when AR goes out again
    logic     rd_err;
    logic     r_hs;
    logic     b_hs;
    logic     r_bad;
    logic     b_bad;
    logic     r_end;
    logic     load_ok;
    logic     store_ok;

    assign r_hs = rvalid && rready;
    assign b_hs = bvalid && bready;

    // A beat fails on a non-OKAY code or a foreign ID
    assign r_bad = (rresp != `RESP_OKAY) || (rid != cur_id);
    assign b_bad = (bresp != `RESP_OKAY) || (bid != cur_id);

    assign r_end    = r_hs && rlast;
    assign load_ok  = r_end && !rd_err && !r_bad;
    assign store_ok = b_hs && !b_bad;

    // Retry on the final handshake so the address goes out on the next cycle
    assign retry = (r_end && (rd_err || r_bad)) || (b_hs && b_bad);

    // ==========================================================================
    // Ready generation and completion pulses
    // ==========================================================================

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            rready     <= 1'b0;
            bready     <= 1'b0;
            rd_idx     <= '0;
            rd_err     <= 1'b0;
            load_done  <= 1'b0;
            store_done <= 1'b0;
            done       <= 1'b0;
        end else begin
            load_done  <= load_ok;
            store_done <= store_ok;
            done       <= load_ok || store_ok;

            // Read burst
            if (addr_sent && kind == LOAD) begin
                rready <= 1'b1;
                rd_idx <= '0;
                rd_err <= 1'b0;
            end else if (r_hs) begin
                rd_idx <= rd_idx + 1'b1;
                if (r_bad)
                    rd_err <= 1'b1;
                if (rlast)
                    rready <= 1'b0;
            end

            // Write response follows the last W beat
            if (wlast_sent)
                bready <= 1'b1;
            else if (b_hs)
                bready <= 1'b0;
        end
    end

    // Good beats land at the running index
    always_ff @(posedge clk) begin
        if (r_hs && !r_bad)
            rdata_buf[rd_idx*`AXI_DATA_W +: `AXI_DATA_W] <= rdata;
    end

    a_one_done: assert property (@(posedge clk) disable iff (!reset)
        !(load_done && store_done));

endmodule

`default_nettype wire

// File: hdl/vlsu_axi_master.sv
// VLSU to AXI4 burst master top level
// Chains request tracker, write beat sequencer and response checker

`timescale 1ns/1ps
`default_nettype none

module vlsu_axi_master (
    input  wire                         clk,
    input  wire                         reset,
    // VLSU side
    input  wire                         ld_req,
    input  wire                         st_req,
    input  wire axi_chan_pkg::axi_addr_t    base_addr,
    input  wire axi_chan_pkg::axi_len_t     burst_len,
    input  wire vlsu_req_pkg::burst_data_t  wdata_buf,
    input  wire vlsu_req_pkg::burst_strb_t  wstrb_buf,
    output logic                        busy,
    output vlsu_req_pkg::burst_data_t   rdata_buf,
    output logic                        load_done,
    output logic                        store_done,
    // Read address
    output logic                        arvalid,
    input  wire                         arready,
    output axi_chan_pkg::axi_id_t       arid,
    output axi_chan_pkg::axi_addr_t     araddr,
    output axi_chan_pkg::axi_len_t      arlen,
    // Read data
    input  wire                         rvalid,
    output logic                        rready,
    input  wire axi_chan_pkg::axi_id_t      rid,
    input  wire axi_chan_pkg::axi_beat_t    rdata,
    input  wire axi_chan_pkg::axi_resp_t    rresp,
    input  wire                         rlast,
    // Write address
    output logic                        awvalid,
    input  wire                         awready,
    output axi_chan_pkg::axi_id_t       awid,
    output axi_chan_pkg::axi_addr_t     awaddr,
    output axi_chan_pkg::axi_len_t      awlen,
    // Write data
    output logic                        wvalid,
    input  wire                         wready,
    output axi_chan_pkg::axi_beat_t     wdata,
    output axi_chan_pkg::axi_strb_t     wstrb,
    output logic                        wlast,
    // Write response
    input  wire                         bvalid,
    output logic                        bready,
    input  wire axi_chan_pkg::axi_id_t      bid,
    input  wire axi_chan_pkg::axi_resp_t    bresp
);

    import axi_chan_pkg::*;
    import vlsu_req_pkg::*;

    // Latched request shared by all three stages
    req_kind_t   kind;
    axi_id_t     cur_id;
    axi_len_t    cur_len;
    burst_data_t cur_data;
    burst_strb_t cur_strb;

    // Stage to stage pulses
    logic aw_sent;
    logic addr_sent;
    logic wlast_sent;
    logic retry;
    logic done;

    axi_req_tracker u_req_tracker (
        .clk       (clk),
        .reset     (reset),
        .ld_req    (ld_req),
        .st_req    (st_req),
        .base_addr (base_addr),
        .burst_len (burst_len),
        .wdata_buf (wdata_buf),
        .wstrb_buf (wstrb_buf),
        .arready   (arready),
        .awready   (awready),
        .retry     (retry),
        .done      (done),
        .arvalid   (arvalid),
        .awvalid   (awvalid),
        .arid      (arid),
        .awid      (awid),
        .araddr    (araddr),
        .awaddr    (awaddr),
        .arlen     (arlen),
        .awlen     (awlen),
        .kind      (kind),
        .cur_id    (cur_id),
        .cur_len   (cur_len),
        .cur_data  (cur_data),
        .cur_strb  (cur_strb),
        .aw_sent   (aw_sent),
        .addr_sent (addr_sent),
        .busy      (busy)
    );

    axi_write_beats u_write_beats (
        .clk        (clk),
        .reset      (reset),
        .kind       (kind),
        .cur_len    (cur_len),
        .cur_data   (cur_data),
        .cur_strb   (cur_strb),
        .aw_sent    (aw_sent),
        .wready     (wready),
        .wvalid     (wvalid),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wlast      (wlast),
        .wlast_sent (wlast_sent)
    );

    axi_resp_check u_resp_check (
        .clk        (clk),
        .reset      (reset),
        .kind       (kind),
        .cur_id     (cur_id),
        .addr_sent  (addr_sent),
        .wlast_sent (wlast_sent),
        .rvalid     (rvalid),
        .rid        (rid),
        .rdata      (rdata),
        .rresp      (rresp),
        .rlast      (rlast),
        .bvalid     (bvalid),
        .bid        (bid),
        .bresp      (bresp),
        .rready     (rready),
        .bready     (bready),
        .rdata_buf  (rdata_buf),
        .load_done  (load_done),
        .store_done (store_done),
        .retry      (retry),
        .done       (done)
    );

endmodule

`default_nettype wire

// File: dv/tb_clock_gen.sv
// Testbench clock and reset source
// Free running clock, reset held low for a fixed number of cycles

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Release on a rising edge so the first active cycle is clean
    initial begin
        reset = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b1;
    end

endmodule

`default_nettype wire

// File: dv/tb_vlsu_axi_master.sv
// Directed testbench for the VLSU AXI4 burst master
// Reactive AXI slave with random ready, error injection and a reference memory

`timescale 1ns/1ps
`default_nettype none

`include "axi_master_defines.svh"

module tb_vlsu_axi_master;

    localparam int CLK_PERIOD = 8;
    localparam int NUM_TESTS  = 5;
    localparam int WAIT_LIMIT = 2000;

    logic         clk;
    logic         reset;
    logic         ld_req;
    logic         st_req;
    logic [31:0]  base_addr;
    logic [7:0]   burst_len;
    logic [255:0] wdata_buf;
    logic [31:0]  wstrb_buf;
    logic         busy;
    logic [255:0] rdata_buf;
    logic         load_done;
    logic         store_done;
    logic         arvalid;
    logic [3:0]   arid;
    logic [31:0]  araddr;
    logic [7:0]   arlen;
    logic         rready;
    logic         awvalid;
    logic [3:0]   awid;
    logic [31:0]  awaddr;
    logic [7:0]   awlen;
    logic         wvalid;
    logic [31:0]  wdata;
    logic [3:0]   wstrb;
    logic         wlast;
    logic         bready;

    // Slave outputs, all registered
    logic         arready = 1'b0;
    logic         rvalid  = 1'b0;
    logic [3:0]   rid     = '0;
    logic [31:0]  rdata   = '0;
    logic [1:0]   rresp   = '0;
    logic         rlast   = 1'b0;
    logic         awready = 1'b0;
    logic         wready  = 1'b0;
    logic         bvalid  = 1'b0;
    logic [3:0]   bid     = '0;
    logic [1:0]   bresp   = '0;

    // Slave state
    logic [31:0]  mem [0:63];
    logic [5:0]   rd_ptr;
    logic [7:0]   rd_left;
    logic [5:0]   wr_ptr;
    logic [3:0]   wr_id;
    logic         wr_bad;
    logic [31:0]  slave_lfsr = 32'hcbd4;
    int           ar_count   = 0;
    int           aw_count   = 0;
    logic [3:0]   ar_id_log   [0:63];
    logic [31:0]  ar_addr_log [0:63];
    logic [7:0]   ar_len_log  [0:63];
    logic [3:0]   aw_id_log   [0:63];
    logic [31:0]  aw_addr_log [0:63];
    logic [7:0]   aw_len_log  [0:63];

    // Burst numbers to corrupt, written only by the tests
    int           bad_ar = -1;
    int           bad_aw = -1;

    // Reference model and bookkeeping
    logic [31:0]  exp_mem [0:63];
    logic [31:0]  data_lfsr = 32'hcbd4;
    int           req_num     = 0;
    int           test_errors = 0;
    int           mon_errors  = 0;
    int           ld_pulses   = 0;
    int           st_pulses   = 0;
    int           tests_run   = 0;
    int           tests_bad   = 0;
    int           errs_at_start;
    logic         ld_prev = 1'b0;
    logic         st_prev = 1'b0;

    tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(8)) u_clock (
        .clk   (clk),
        .reset (reset)
    );

    vlsu_axi_master uut (
        .clk(clk), .reset(reset),
        .ld_req(ld_req), .st_req(st_req), .base_addr(base_addr), .burst_len(burst_len),
        .wdata_buf(wdata_buf), .wstrb_buf(wstrb_buf), .busy(busy), .rdata_buf(rdata_buf),
        .load_done(load_done), .store_done(store_done),
        .arvalid(arvalid), .arready(arready), .arid(arid), .araddr(araddr), .arlen(arlen),
        .rvalid(rvalid), .rready(rready), .rid(rid), .rdata(rdata), .rresp(rresp),
        .rlast(rlast),
        .awvalid(awvalid), .awready(awready), .awid(awid), .awaddr(awaddr), .awlen(awlen),
        .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb), .wlast(wlast),
        .bvalid(bvalid), .bready(bready), .bid(bid), .bresp(bresp)
    );

    // Right shifting Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // Power-up contents, a function of the full word address
    function automatic logic [31:0] fill_word(input int i);
        fill_word = 32'h1357_0000 ^ (i * 32'h0101_0107);
    endfunction

    // ========================================================================
    // Reactive AXI slave
    // ========================================================================

    always @(posedge clk) begin : slave
        logic [31:0] s1;
        logic [31:0] s2;
        logic [31:0] s3;
        if (!reset) begin
            for (int i = 0; i < 64; i++)
                mem[i] <= fill_word(i);
            arready <= 1'b0;
            awready <= 1'b0;
            wready  <= 1'b0;
            rvalid  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            // One LFSR step per ready bit
            s1 = lfsr_next(slave_lfsr);
            s2 = lfsr_next(s1);
            s3 = lfsr_next(s2);
            arready    <= s1[0];
            awready    <= s2[0];
            wready     <= s3[0];
            slave_lfsr <= s3;

            // Read burst, SLVERR on every beat of a corrupted one
            if (arvalid && arready) begin
                rvalid  <= 1'b1;
                rid     <= arid;
                rresp   <= (ar_count == bad_ar) ? `RESP_SLVERR : `RESP_OKAY;
                rdata   <= mem[araddr[7:2]];
                rd_ptr  <= araddr[7:2] + 6'd1;
                rd_left <= arlen;
                rlast   <= (arlen == 8'd0);
                ar_id_log[ar_count % 64]   <= arid;
                ar_addr_log[ar_count % 64] <= araddr;
                ar_len_log[ar_count % 64]  <= arlen;
                ar_count <= ar_count + 1;
            end else if (rvalid && rready) begin
                if (rlast) begin
                    rvalid <= 1'b0;
                end else begin
                    rdata   <= mem[rd_ptr];
                    rd_ptr  <= rd_ptr + 6'd1;
                    rd_left <= rd_left - 8'd1;
                    rlast   <= (rd_left == 8'd1);
                end
            end

            // Write burst, a corrupted one answers with a foreign ID
            if (awvalid && awready) begin
                wr_ptr <= awaddr[7:2];
                wr_id  <= awid;
                wr_bad <= (aw_count == bad_aw);
                aw_id_log[aw_count % 64]   <= awid;
                aw_addr_log[aw_count % 64] <= awaddr;
                aw_len_log[aw_count % 64]  <= awlen;
                aw_count <= aw_count + 1;
            end
            if (wvalid && wready) begin
                for (int k = 0; k < 4; k++)
                    if (wstrb[k])
                        mem[wr_ptr][k*8 +: 8] <= wdata[k*8 +: 8];
                wr_ptr <= wr_ptr + 6'd1;
                if (wlast) begin
                    bvalid <= 1'b1;
                    bid    <= wr_bad ? (wr_id ^ 4'h1) : wr_id;
                    bresp  <= `RESP_OKAY;
                end
            end
            if (bvalid && bready)
                bvalid <= 1'b0;
        end
    end

    // Completion pulse counter, each pulse one cycle wide
    always @(posedge clk) begin
        if (reset) begin
            if (load_done)
                ld_pulses++;
            if (store_done)
                st_pulses++;
            assert (!(load_done && ld_prev) && !(store_done && st_prev)) else begin
                $display("completion pulse held high for more than one cycle at %0t", $time);
                mon_errors++;
            end
        end
        ld_prev <= load_done;
        st_prev <= store_done;
    end

    // Watchdog sized for the whole test list
    initial begin
        #(NUM_TESTS * WAIT_LIMIT * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("Result: FAILED");
        $finish;
    end

    // ========================================================================
    // Test helpers
    // ========================================================================

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic next_rand(output logic [31:0] w);
        w = '0;
        for (int i = 0; i < 32; i++) begin
            data_lfsr = lfsr_next(data_lfsr);
            w = {w[30:0], data_lfsr[0]};
        end
    endtask

    // Issue one request, wait for completion and check ID and pulse count
    task automatic run_req(input bit is_load, input logic [5:0] word, input logic [7:0] len,
                           input logic [255:0] data, input logic [31:0] strb,
                           input bit poke_busy);
        int ar0;
        int aw0;
        int ld0;
        int st0;
        int n;
        logic [3:0] exp_id;
        ar0 = ar_count;
        aw0 = aw_count;
        ld0 = ld_pulses;
        st0 = st_pulses;
        exp_id = req_num[3:0];
        @(posedge clk);
        base_addr <= {24'd0, word, 2'b00};
        burst_len <= len;
        wdata_buf <= data;
        wstrb_buf <= strb;
        ld_req    <= is_load;
        st_req    <= !is_load;
        @(posedge clk);
        ld_req <= 1'b0;
        st_req <= poke_busy;
        @(posedge clk);
        st_req <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!(is_load ? load_done : store_done) && n < WAIT_LIMIT);
        assert (n < WAIT_LIMIT) else begin
            $display("no completion pulse within %0d cycles", WAIT_LIMIT);
            test_errors++;
        end
        check_eq("busy", {31'd0, busy}, 32'd0);
        repeat (2) @(negedge clk);
        check_eq("load_done count", ld_pulses - ld0, is_load ? 1 : 0);
        check_eq("store_done count", st_pulses - st0, is_load ? 0 : 1);
        if (is_load) begin
            check_eq("arid", {28'd0, ar_id_log[ar0 % 64]}, {28'd0, exp_id});
            check_eq("araddr", ar_addr_log[ar0 % 64], {24'd0, word, 2'b00});
            check_eq("arlen", {24'd0, ar_len_log[ar0 % 64]}, {24'd0, len});
        end else begin
            check_eq("awid", {28'd0, aw_id_log[aw0 % 64]}, {28'd0, exp_id});
            check_eq("awaddr", aw_addr_log[aw0 % 64], {24'd0, word, 2'b00});
            check_eq("awlen", {24'd0, aw_len_log[aw0 % 64]}, {24'd0, len});
        end
        if (poke_busy)
            check_eq("aw transfers", aw_count - aw0, 0);
        req_num++;
    endtask

    task automatic do_load(input logic [5:0] word, input logic [7:0] len);
        logic [5:0] idx;
        run_req(1'b1, word, len, '0, '0, 1'b0);
        for (int b = 0; b <= int'(len); b++) begin
            idx = word + b[5:0];
            check_eq("rdata_buf", rdata_buf[b*32 +: 32], exp_mem[idx]);
        end
    endtask

    // Store LFSR data and merge it into the reference by strobe
    task automatic do_store(input logic [5:0] word, input logic [7:0] len, input bit partial);
        logic [255:0] data;
        logic [31:0]  strb;
        logic [31:0]  r;
        logic [5:0]   idx;
        data = '0;
        strb = '0;
        for (int b = 0; b <= int'(len); b++) begin
            next_rand(r);
            data[b*32 +: 32] = r;
            next_rand(r);
            strb[b*4 +: 4] = partial ? (r[3:0] & 4'hd) : 4'hf;
            idx = word + b[5:0];
            for (int k = 0; k < 4; k++)
                if (strb[b*4 + k])
                    exp_mem[idx][k*8 +: 8] = data[b*32 + k*8 +: 8];
        end
        run_req(1'b0, word, len, data, strb, 1'b0);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errors + mon_errors != errs_at_start)
            tests_bad++;
        $display("test %-18s %s", name,
                 (test_errors + mon_errors == errs_at_start) ? "ok" : "with errors");
        errs_at_start = test_errors + mon_errors;
    endtask

    // ========================================================================
    // Directed tests
    // ========================================================================

    initial begin
        int ar0;
        int aw0;
        ld_req    = 1'b0;
        st_req    = 1'b0;
        base_addr = '0;
        burst_len = '0;
        wdata_buf = '0;
        wstrb_buf = '0;
        for (int i = 0; i < 64; i++)
            exp_mem[i] = fill_word(i);
        errs_at_start = 0;
        @(posedge reset);
        repeat (2) @(negedge clk);

        // Full strobe bursts of 1, 4 and 8 beats
        do_store(6'd0, 8'd0, 1'b0);
        do_store(6'd8, 8'd3, 1'b0);
        do_store(6'd16, 8'd7, 1'b0);
        do_load(6'd0, 8'd0);
        do_load(6'd8, 8'd3);
        do_load(6'd16, 8'd7);
        end_test("store_then_load");

        do_store(6'd32, 8'd3, 1'b0);
        do_store(6'd32, 8'd3, 1'b1);
        do_load(6'd32, 8'd3);
        end_test("strobes");

        // First AR of this load gets SLVERR
        ar0 = ar_count;
        bad_ar = ar_count;
        do_load(6'd40, 8'd7);
        check_eq("ar transfers", ar_count - ar0, 2);
        check_eq("retry arid", {28'd0, ar_id_log[(ar0 + 1) % 64]}, {28'd0, ar_id_log[ar0 % 64]});
        check_eq("retry araddr", ar_addr_log[(ar0 + 1) % 64], ar_addr_log[ar0 % 64]);
        end_test("read_error_retry");

        aw0 = aw_count;
        bad_aw = aw_count;
        do_store(6'd48, 8'd5, 1'b0);
        check_eq("aw transfers", aw_count - aw0, 2);
        check_eq("retry awid", {28'd0, aw_id_log[(aw0 + 1) % 64]}, {28'd0, aw_id_log[aw0 % 64]});
        check_eq("retry awaddr", aw_addr_log[(aw0 + 1) % 64], aw_addr_log[aw0 % 64]);
        do_load(6'd48, 8'd5);
        end_test("write_id_retry");

        // Enough requests to wrap the 4 bit ID, then a store pulsed while busy
        for (int i = 0; i < 18; i++)
            do_load(i[5:0], 8'd0);
        ar0 = ar_count;
        run_req(1'b1, 6'd20, 8'd1, '0, '0, 1'b1);
        check_eq("ar transfers", ar_count - ar0, 1);
        end_test("id_sequence");

        $display("tests run %0d, with errors %0d, checks failed %0d",
                 tests_run, tests_bad, test_errors + mon_errors);
        if (test_errors + mon_errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+include
hdl/axi_chan_pkg.sv
hdl/vlsu_req_pkg.sv
hdl/axi_req_tracker.sv
hdl/axi_write_beats.sv
hdl/axi_resp_check.sv
hdl/vlsu_axi_master.sv
dv/tb_clock_gen.sv
dv/tb_vlsu_axi_master.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the VLSU AXI master testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module tb_vlsu_axi_master -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation aborted"; exit 1; }

cat sim.log
grep -q "Result: FAILED" sim.log \
    && { echo "simulation reported failure"; exit 1; } \
    || { echo "simulation clean"; exit 0; }
